//--- files.f
+incdir+src
src/sifhDataPkg.sv
src/sifhRegPkg.sv
src/histRam.sv
src/peakFinder.sv
src/sifhRegs.sv
src/sifhHistFsm.sv
src/sifhTop.sv
verification/tbClock.sv
verification/sifhTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the histogram testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module sifhTb -f files.f -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the testbench prints the fail line on any mismatch or timeout
if grep -q "RESULT: FAIL" sim.log; then
    echo "simulation reported failure, see sim.log"
    exit 1
fi
exit 0

//--- src/histRam.sv
`timescale 1ns/1ns
`include "sifh_settings.svh"

module histRam import sifhDataPkg::*; (
    input  logic   clk,
    // port a, write
    input  bin_t   waddr,
    input  logic   wEnable,
    input  count_t newCounts,
    // port b, read
    input  bin_t   raddr,
    input  logic   rEnable,
    output count_t counts
);

    // one word per bin
    count_t mem [`BIN_NUM];

    // write side
    always_ff @(posedge clk) begin
        if (wEnable) begin
            mem[waddr] <= newCounts;
        end
    end

    // registered read
    // a same-cycle write to the same bin is not seen, old word comes out
    always_ff @(posedge clk) begin
        if (rEnable) begin
            counts <= mem[raddr];
        end
    end

endmodule

//--- src/peakFinder.sv
`timescale 1ns/1ns

module peakFinder import sifhDataPkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  count_t counts,
    input  logic   scanValid,
    input  logic   scanFirst,
    input  logic   scanLast,
    input  bin_t   scanBin,
    output bin_t   peakBin,
    output count_t peakCount,
    output logic   peakValid
);

    // running best so far
    count_t bestCount;
    bin_t bestBin;
    logic takeNew;

    // first word always taken
    // strictly greater only, earlier bin keeps a tie
    assign takeNew = scanFirst || (counts > bestCount);

    // running maximum
    always_ff @(posedge clk) begin
        if (scanValid && takeNew) begin
            bestCount <= counts;
            bestBin <= scanBin;
        end
    end

    // final pair includes the last word itself
    always_ff @(posedge clk) begin
        if (scanValid && scanLast) begin
            peakCount <= takeNew ? counts : bestCount;
            peakBin <= takeNew ? scanBin : bestBin;
        end
    end

    // result strobe, one cycle after the last word
    always_ff @(posedge clk) begin
        if (!rstN) begin
            peakValid <= 1'b0;
        end else begin
            peakValid <= scanValid && scanLast;
        end
    end

endmodule

//--- src/sifhDataPkg.sv
package sifhDataPkg;

    `include "sifh_settings.svh"

    // one bin counter word
    typedef logic [`peakMax-1:0] count_t;

    // bin index, also the RAM address
    typedef logic [`Nb-1:0] bin_t;

    // incoming timestamp, read both as a bin and as a marker
    typedef union packed {
        struct packed {
            bin_t bin;
            logic [`Np-`Nb-1:0] fine;
        } hist;
        struct packed {
            logic [`Np-2:0] marker;
            logic code;
        } mark;
    } tdcWord_u;

    // histogram controller states
    // IDLE only until the first clear, RAM content unknown there
    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        RUN,
        DRAIN,
        SCAN
    } histState_e;

endpackage

//--- src/sifhHistFsm.sv
`timescale 1ns/1ns
`include "sifh_settings.svh"

module sifhHistFsm import sifhDataPkg::*; (
    input  logic            clk,
    input  logic            rstN,
    input  logic [`Np-1:0]  data,
    input  logic            dataValid,
    input  logic            clearStart,
    input  count_t          counts,
    output bin_t            waddr,
    output bin_t            raddr,
    output logic            wEnable,
    output logic            rEnable,
    output count_t          newCounts,
    output logic            scanValid,
    output logic            scanFirst,
    output logic            scanLast,
    output bin_t            scanBin,
    output logic            busy,
    output logic            dropPulse,
    output logic            scanDone
);

    localparam bin_t lastBin = bin_t'(`BIN_NUM - 1);

    tdcWord_u word;
    logic isMarker;
    logic isIdleWord;
    logic isEndWord;
    logic accept;
    logic endSeen;
    histState_e state;
    // sweep index for clear and scan, drain cycle count in DRAIN
    bin_t binCnt;
    // stage 1, read issued, count returning
    logic s1Valid;
    bin_t s1Bin;
    // stage 2, incremented count on the write port
    logic s2Valid;
    bin_t s2Bin;
    count_t s2Count;
    // stage 3, word written last cycle, RAM read may have missed it
    logic s3Valid;
    bin_t s3Bin;
    count_t s3Count;
    count_t baseCount;

    // decode the same word both ways
    assign word = data;
    assign isMarker = &word.mark.marker;
    assign isIdleWord = isMarker && word.mark.code;
    assign isEndWord = isMarker && !word.mark.code;

    // busy through the final scan data cycle, so peak and done line up
    assign busy = (state == CLEAR) || (state == DRAIN) || (state == SCAN) || scanLast;

    // only back-pressure, idle words never count as drops
    assign dropPulse = dataValid && busy && !isIdleWord;
    assign accept = dataValid && (state == RUN) && !busy && !isMarker;
    assign endSeen = dataValid && (state == RUN) && !busy && isEndWord;

    // read port, scan sweep or bin lookup
    assign rEnable = accept || (state == SCAN);
    assign raddr = (state == SCAN) ? binCnt : word.hist.bin;

    // write port, clear sweep overrides pipeline
    assign wEnable = (state == CLEAR) || s2Valid;
    assign waddr = (state == CLEAR) ? binCnt : s2Bin;
    assign newCounts = (state == CLEAR) ? '0 : s2Count;

    // newest pending value first
    always_comb begin
        if (s2Valid && (s2Bin == s1Bin)) begin
            baseCount = s2Count;
        end else if (s3Valid && (s3Bin == s1Bin)) begin
            baseCount = s3Count;
        end else begin
            baseCount = counts;
        end
    end

    // update pipeline valids
    // in-flight updates die on a clear
    always_ff @(posedge clk) begin
        if (!rstN) begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
            s3Valid <= 1'b0;
        end else begin
            s1Valid <= accept;
            s2Valid <= s1Valid && (state != CLEAR);
            s3Valid <= s2Valid && (state != CLEAR);
        end
    end

    // pipeline payload, saturating increment
    always_ff @(posedge clk) begin
        s1Bin <= word.hist.bin;
        s2Bin <= s1Bin;
        s2Count <= (baseCount == '1) ? baseCount : baseCount + 1'b1;
        s3Bin <= s2Bin;
        s3Count <= s2Count;
    end

    // state and sweep counter
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= IDLE;
            binCnt <= '0;
        end else if (clearStart) begin
            state <= CLEAR;
            binCnt <= '0;
        end else begin
            case (state)
                CLEAR: begin
                    binCnt <= binCnt + 1'b1;
                    if (binCnt == lastBin) begin
                        state <= RUN;
                    end
                end
                RUN: begin
                    if (endSeen) begin
                        state <= DRAIN;
                        binCnt <= '0;
                    end
                end
                DRAIN: begin
                    // two cycles, last update write lands in the first
                    binCnt <= binCnt + 1'b1;
                    if (binCnt == bin_t'(1)) begin
                        state <= SCAN;
                        binCnt <= '0;
                    end
                end
                SCAN: begin
                    binCnt <= binCnt + 1'b1;
                    if (binCnt == lastBin) begin
                        state <= RUN;
                    end
                end
                default: begin
                    // IDLE waits for the first clear
                    binCnt <= '0;
                end
            endcase
        end
    end

    // scan tags follow the read by one cycle, in step with counts
    always_ff @(posedge clk) begin
        if (!rstN) begin
            scanValid <= 1'b0;
            scanFirst <= 1'b0;
            scanLast <= 1'b0;
            scanDone <= 1'b0;
        end else begin
            scanValid <= (state == SCAN) && !clearStart;
            scanFirst <= (state == SCAN) && !clearStart && (binCnt == '0);
            scanLast <= (state == SCAN) && !clearStart && (binCnt == lastBin);
            scanDone <= scanLast && !clearStart;
        end
    end

    always_ff @(posedge clk) begin
        scanBin <= binCnt;
    end

endmodule

//--- src/sifhRegPkg.sv
package sifhRegPkg;

    `include "sifh_settings.svh"

    // register map
    typedef enum logic [`REG_AW-1:0] {
        CTRL      = 3'd0,
        STATUS    = 3'd1,
        DROPS     = 3'd2,
        PEAKBIN   = 3'd3,
        PEAKCOUNT = 3'd4
    } regAddr_e;

    // CTRL bits, write one to act
    localparam int CTRL_CLEAR = 0;

    // STATUS bits
    // busy while clearing, draining or scanning
    localparam int STATUS_BUSY = 0;
    // set by end of scan, dropped by clear
    localparam int STATUS_DONE = 1;

endpackage

//--- src/sifhRegs.sv
`timescale 1ns/1ns
`include "sifh_settings.svh"

module sifhRegs import sifhDataPkg::*, sifhRegPkg::*; (
    input  logic              clk,
    input  logic              rstN,
    input  logic              regWrEn,
    input  logic              regRdEn,
    input  logic [`REG_AW-1:0] regAddr,
    input  logic [`REG_DW-1:0] regWdata,
    input  logic              busy,
    input  logic              dropPulse,
    input  logic              scanDone,
    input  bin_t              peakBin,
    input  count_t            peakCount,
    input  logic              peakValid,
    output logic [`REG_DW-1:0] regRdata,
    output logic              clearStart
);

    // done flag, survives until next clear
    logic done;
    // words lost to back-pressure
    logic [`REG_DW-1:0] drops;
    // peak result held for readout
    bin_t peakBinQ;
    count_t peakCountQ;
    logic [`REG_DW-1:0] statusWord;

    // status bits assembled from live busy and held done
    always_comb begin
        statusWord = '0;
        statusWord[STATUS_BUSY] = busy;
        statusWord[STATUS_DONE] = done;
    end

    // control, done and drop counter
    always_ff @(posedge clk) begin
        if (!rstN) begin
            clearStart <= 1'b0;
            done <= 1'b0;
            drops <= '0;
        end else begin
            // clear bit is self clearing, only the pulse leaves here
            clearStart <= regWrEn && (regAddr == CTRL) && regWdata[CTRL_CLEAR];
            if (clearStart) begin
                done <= 1'b0;
            end else if (scanDone) begin
                done <= 1'b1;
            end
            // saturate rather than wrap
            if (dropPulse && (drops != '1)) begin
                drops <= drops + 1'b1;
            end
        end
    end

    // peak result latch
    always_ff @(posedge clk) begin
        if (!rstN) begin
            peakBinQ <= '0;
            peakCountQ <= '0;
        end else if (peakValid) begin
            peakBinQ <= peakBin;
            peakCountQ <= peakCount;
        end
    end

    // read data, one cycle after the strobe
    always_ff @(posedge clk) begin
        if (!rstN) begin
            regRdata <= '0;
        end else if (regRdEn) begin
            case (regAddr_e'(regAddr))
                STATUS:    regRdata <= statusWord;
                DROPS:     regRdata <= drops;
                PEAKBIN:   regRdata <= `REG_DW'(peakBinQ);
                PEAKCOUNT: regRdata <= `REG_DW'(peakCountQ);
                // CTRL reads back zero
                default:   regRdata <= '0;
            endcase
        end
    end

endmodule

//--- src/sifhTop.sv
`timescale 1ns/1ns
`include "sifh_settings.svh"

module sifhTop import sifhDataPkg::*; (
    input  logic              clk,
    input  logic              rstN,
    input  logic [`Np-1:0]     data,
    input  logic              dataValid,
    input  logic              regWrEn,
    input  logic              regRdEn,
    input  logic [`REG_AW-1:0] regAddr,
    input  logic [`REG_DW-1:0] regWdata,
    output logic [`REG_DW-1:0] regRdata,
    output logic              busy
);

    // register block to controller
    logic clearStart;
    // controller to register block
    logic dropPulse;
    logic scanDone;
    // RAM ports
    bin_t waddr;
    bin_t raddr;
    logic wEnable;
    logic rEnable;
    count_t newCounts;
    count_t counts;
    // scan stream to peak search
    logic scanValid;
    logic scanFirst;
    logic scanLast;
    bin_t scanBin;
    // peak result
    bin_t peakBin;
    count_t peakCount;
    logic peakValid;

    sifhRegs i_regs (
        .clk(clk),
        .rstN(rstN),
        .regWrEn(regWrEn),
        .regRdEn(regRdEn),
        .regAddr(regAddr),
        .regWdata(regWdata),
        .busy(busy),
        .dropPulse(dropPulse),
        .scanDone(scanDone),
        .peakBin(peakBin),
        .peakCount(peakCount),
        .peakValid(peakValid),
        .regRdata(regRdata),
        .clearStart(clearStart)
    );

    sifhHistFsm i_histFsm (
        .clk(clk),
        .rstN(rstN),
        .data(data),
        .dataValid(dataValid),
        .clearStart(clearStart),
        .counts(counts),
        .waddr(waddr),
        .raddr(raddr),
        .wEnable(wEnable),
        .rEnable(rEnable),
        .newCounts(newCounts),
        .scanValid(scanValid),
        .scanFirst(scanFirst),
        .scanLast(scanLast),
        .scanBin(scanBin),
        .busy(busy),
        .dropPulse(dropPulse),
        .scanDone(scanDone)
    );

    histRam i_histRam (
        .clk(clk),
        .waddr(waddr),
        .wEnable(wEnable),
        .newCounts(newCounts),
        .raddr(raddr),
        .rEnable(rEnable),
        .counts(counts)
    );

    peakFinder i_peakFinder (
        .clk(clk),
        .rstN(rstN),
        .counts(counts),
        .scanValid(scanValid),
        .scanFirst(scanFirst),
        .scanLast(scanLast),
        .scanBin(scanBin),
        .peakBin(peakBin),
        .peakCount(peakCount),
        .peakValid(peakValid)
    );

endmodule

//--- src/sifh_settings.svh
`ifndef SIFH_SETTINGS_SVH
`define SIFH_SETTINGS_SVH

// timestamp word width from the pixel TDC
`define Np 10

// bin select, taken from the top of the timestamp
`define Nb 6

// histogram count width, saturating
`define peakMax 12

// number of histogram bins
`define BIN_NUM (2 ** `Nb)

// reserved words at the top of the timestamp range
`define MARK_IDLE ({`Np{1'b1}})
`define MARK_END ({{(`Np - 1){1'b1}}, 1'b0})

// register access
`define REG_AW 3
`define REG_DW 16

`endif

//--- verification/sifhTb.sv
`timescale 1ns/1ns
`include "sifh_settings.svh"

module sifhTb import sifhDataPkg::*, sifhRegPkg::*; ();

    // words sent over all tests, markers included
    localparam int WORD_TOTAL = 300 + 40 + 130 + 4100 + 5;
    localparam int TEST_COUNT = 5;
    // each test adds at most a clear, a scan and some polling
    localparam int WATCH_CYCLES = 2 * (WORD_TOTAL + TEST_COUNT * 4 * `BIN_NUM) + 1000;
    localparam logic [`Np-1:0] IDLE_WORD = `MARK_IDLE;
    localparam logic [`Np-1:0] END_WORD = `MARK_END;
    localparam int COUNT_TOP = (1 << `peakMax) - 1;

    logic clk;
    logic rstN;
    logic [`Np-1:0] data;
    logic dataValid;
    logic regWrEn;
    logic regRdEn;
    logic [`REG_AW-1:0] regAddr;
    logic [`REG_DW-1:0] regWdata;
    logic [`REG_DW-1:0] regRdata;
    logic busy;

    // reference histogram
    int model [`BIN_NUM];
    // non-idle words sent while busy
    int expDrops;
    logic [15:0] lfsr;
    int errors;
    int checks;
    int testErrors;
    int testsFailed;

    tbClock i_clock (
        .clk(clk),
        .rstN(rstN)
    );

    sifhTop i_dut (
        .clk(clk),
        .rstN(rstN),
        .data(data),
        .dataValid(dataValid),
        .regWrEn(regWrEn),
        .regRdEn(regRdEn),
        .regAddr(regAddr),
        .regWdata(regWdata),
        .regRdata(regRdata),
        .busy(busy)
    );

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    // one step per bit taken
    task automatic randomBits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            v = {v[14:0], lfsr[0]};
        end
    endtask

    // inputs change 10 ns after the edge
    task automatic nextCycle();
        @(posedge clk);
        #10;
    endtask

    task automatic checkValue(input string what, input int got, input int expected);
        checks++;
        if (got != expected) begin
            $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
            errors++;
            testErrors++;
        end
    endtask

    task automatic regWrite(input regAddr_e addr, input logic [`REG_DW-1:0] value);
        regAddr = addr;
        regWdata = value;
        regWrEn = 1'b1;
        nextCycle();
        regWrEn = 1'b0;
    endtask

    // read data is registered at the edge that takes the strobe
    task automatic regRead(input regAddr_e addr, output logic [`REG_DW-1:0] value);
        regAddr = addr;
        regRdEn = 1'b1;
        nextCycle();
        regRdEn = 1'b0;
        value = regRdata;
    endtask

    // returns once the clear sweep is running
    task automatic startClear();
        int cycles;
        regWrite(CTRL, `REG_DW'(1 << CTRL_CLEAR));
        cycles = 0;
        while (!busy) begin
            nextCycle();
            cycles++;
        end
        // busy follows the clear pulse by one cycle
        checkValue("busy delay after clear", cycles, 1);
        for (int b = 0; b < `BIN_NUM; b++) begin
            model[b] = 0;
        end
    endtask

    // one zero write per bin while busy
    task automatic waitClear();
        int cycles;
        cycles = 0;
        while (busy) begin
            nextCycle();
            cycles++;
        end
        checkValue("clear busy cycles", cycles, `BIN_NUM);
    endtask

    // busy seen now is what the DUT sees at the next edge
    task automatic sendWord(input logic [`Np-1:0] w);
        int bin;
        bin = int'(w[`Np-1:`Np-`Nb]);
        data = w;
        dataValid = 1'b1;
        if (busy) begin
            if (w != IDLE_WORD) begin
                expDrops++;
            end
        end else if (w[`Np-1:1] != IDLE_WORD[`Np-1:1]) begin
            if (model[bin] < COUNT_TOP) begin
                model[bin]++;
            end
        end
        nextCycle();
        dataValid = 1'b0;
    endtask

    // about one word in eight is idle, no end markers
    task automatic randomWord(output logic [`Np-1:0] w);
        logic [15:0] r;
        randomBits(3, r);
        if (r[2:0] == 3'd0) begin
            w = IDLE_WORD;
        end else begin
            randomBits(`Np, r);
            w = r[`Np-1:0];
            if (w == END_WORD) begin
                w = IDLE_WORD;
            end
        end
    endtask

    task automatic waitDone();
        logic [`REG_DW-1:0] status;
        status = '0;
        while (!(status[STATUS_DONE] && !status[STATUS_BUSY])) begin
            regRead(STATUS, status);
        end
    endtask

    // highest count, lowest bin on a tie
    task automatic checkPeak();
        int bestBin;
        int bestCount;
        logic [`REG_DW-1:0] v;
        bestBin = 0;
        bestCount = model[0];
        for (int b = 1; b < `BIN_NUM; b++) begin
            if (model[b] > bestCount) begin
                bestBin = b;
                bestCount = model[b];
            end
        end
        regRead(PEAKBIN, v);
        checkValue("peak bin", int'(v), bestBin);
        regRead(PEAKCOUNT, v);
        checkValue("peak count", int'(v), bestCount);
    endtask

    task automatic endTest(input int num, input string name);
        if (testErrors == 0) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d mismatches", num, name, testErrors);
            testsFailed++;
        end
        testErrors = 0;
    endtask

    initial begin
        logic [`Np-1:0] w;
        logic [15:0] r;
        logic [`REG_DW-1:0] v;
        int dropsBefore;
        bin_t bin;
        data = '0;
        dataValid = 1'b0;
        regWrEn = 1'b0;
        regRdEn = 1'b0;
        regAddr = '0;
        regWdata = '0;
        lfsr = 16'd54;
        errors = 0;
        checks = 0;
        testErrors = 0;
        testsFailed = 0;
        expDrops = 0;
        @(posedge rstN);
        nextCycle();

        // random timestamps, idle words in between
        startClear();
        waitClear();
        for (int i = 0; i < 300; i++) begin
            randomWord(w);
            sendWord(w);
        end
        sendWord(END_WORD);
        waitDone();
        checkPeak();
        endTest(1, "random timestamps");

        // back to back hits on one bin go through forwarding
        startClear();
        waitClear();
        randomBits(`Nb, r);
        bin = r[`Nb-1:0];
        for (int i = 0; i < 40; i++) begin
            randomBits(`Np - `Nb - 1, r);
            sendWord({bin, 1'b0, r[`Np-`Nb-2:0]});
        end
        sendWord(END_WORD);
        waitDone();
        checkPeak();
        regRead(PEAKCOUNT, v);
        checkValue("burst count", int'(v), 40);
        endTest(2, "same bin burst");

        // words during clear and scan are dropped and counted
        regRead(DROPS, v);
        dropsBefore = int'(v);
        expDrops = 0;
        startClear();
        for (int i = 0; i < 100; i++) begin
            randomWord(w);
            sendWord(w);
        end
        sendWord(END_WORD);
        for (int i = 0; i < 30; i++) begin
            randomWord(w);
            sendWord(w);
        end
        waitDone();
        regRead(DROPS, v);
        checkValue("drop count", int'(v) - dropsBefore, expDrops);
        checkPeak();
        endTest(3, "drops while busy");

        // count stops at all ones
        startClear();
        waitClear();
        randomBits(`Nb, r);
        bin = r[`Nb-1:0];
        for (int i = 0; i < 4100; i++) begin
            sendWord({bin, {(`Np - `Nb){1'b0}}});
        end
        sendWord(END_WORD);
        waitDone();
        checkPeak();
        regRead(PEAKCOUNT, v);
        checkValue("saturated count", int'(v), COUNT_TOP);
        endTest(4, "count saturation");

        // empty histogram, then done drops on the next clear
        startClear();
        waitClear();
        sendWord(END_WORD);
        // scan under way, done left over from the last test already dropped
        regRead(STATUS, v);
        checkValue("status during scan", int'(v), 1 << STATUS_BUSY);
        waitDone();
        checkPeak();
        startClear();
        waitClear();
        regRead(STATUS, v);
        checkValue("done after clear", int'(v[STATUS_DONE]), 0);
        endTest(5, "empty scan and done");

        $display("tests run %0d, tests failed %0d, checks %0d, mismatches %0d",
                 TEST_COUNT, testsFailed, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // hang guard
    initial begin
        repeat (WATCH_CYCLES) @(posedge clk);
        $display("run timed out after %0d clock cycles without finishing", WATCH_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- verification/tbClock.sv
`timescale 1ns/1ns

module tbClock (
    output logic clk,
    output logic rstN
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset held low for four rising edges
    initial begin
        rstN = 1'b0;
        repeat (4) @(posedge clk);
        #10;
        rstN = 1'b1;
    end

endmodule
